// File: tb.f
hw/rp_pkg.sv
hw/adc_frontend.sv
hw/dac_frontend.sv
hw/pdm_modulator.sv
hw/sys_regs.sv
hw/rp_top.sv
sim/rp_top_props.sv
sim/rp_top_tb.sv

// File: Makefile
# Verilator build and run of the rp_top testbench

VERILATOR ?= verilator
TOP       ?= rp_top_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/rp_top_tb.sv
/*
 * Testbench for rp_top. Drives the system bus and the ADC inputs,
 * checks readback, DAC codes, loopback and PDM density against
 * reference functions, prints one line per test and a summary.
 */

`timescale 1ns/1ps
`default_nettype none

module rp_top_tb;

  import rp_pkg::*;

  localparam int CLK_HALF    = 4;
  localparam int DRV_DLY     = 1;
  localparam int ACK_TIMEOUT = 20;
  localparam int PDM_SETTLE  = 16;
  localparam int NUM_ITER    = 4;

  logic                           adc_clk;
  logic                           top_rst;
  logic [CHN_NUM-1:0][ADC_DW-1:0] adc_dat;
  logic [CHN_NUM-1:0][DAC_DW-1:0] dac_dat;
  logic [PDM_CHN-1:0]             dac_pwm;
  logic [BUS_AW-1:0]              bus_addr;
  logic [BUS_DW-1:0]              bus_wdata;
  logic                           bus_wen;
  logic                           bus_ren;
  logic [BUS_DW-1:0]              bus_rdata;
  logic                           bus_ack;

  int seed;
  int check_cnt;
  int err_cnt;
  int test_cnt;

  // Running test and its error count at the start
  string test_name;
  int    err_mark;

  // 8 ns clock period
  always #(CLK_HALF) adc_clk = ~adc_clk;

  rp_top rp_top_i (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat),
    .dac_dat_o   (dac_dat),
    .dac_pwm_o   (dac_pwm),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_wen_i   (bus_wen),
    .bus_ren_i   (bus_ren),
    .bus_rdata_o (bus_rdata),
    .bus_ack_o   (bus_ack)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////////////////////////

  // Negative slope input, every bit below the sign flips
  function automatic adc_t adc_ref(input logic [ADC_DW-1:0] raw);
    adc_ref = adc_t'(raw ^ {1'b0, {(ADC_DW-1){1'b1}}});
  endfunction

  function automatic logic [DAC_DW-1:0] dac_ref(input dac_t val);
    dac_ref = val ^ {1'b0, {(DAC_DW-1){1'b1}}};
  endfunction

  // Loopback keeps the top DAC_DW bits of the sample
  function automatic dac_t loop_ref(input adc_t smp);
    loop_ref = dac_t'(smp >>> (ADC_DW - DAC_DW));
  endfunction

  // Ideal density: a one each time d*k/RNG crosses an integer
  function automatic int pdm_ones_ref(input int unsigned duty);
    int ones;
    ones = 0;
    for (int unsigned k = 0; k < PDM_RNG; k++) begin
      if ((k + 1) * duty / PDM_RNG != k * duty / PDM_RNG) begin
        ones++;
      end
    end
    pdm_ones_ref = ones;
  endfunction

  // Signed size casts widen with the sign bit
  function automatic logic [BUS_DW-1:0] sext_adc(input adc_t v);
    sext_adc = BUS_DW'(v);
  endfunction

  function automatic logic [BUS_DW-1:0] sext_dac(input dac_t v);
    sext_dac = BUS_DW'(v);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [BUS_DW-1:0] exp,
                            input logic [BUS_DW-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_dac(input string name, input logic [DAC_DW-1:0] exp,
                           input logic [DAC_DW-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    check_cnt++;
    if (act != exp) begin
      err_cnt++;
      $display("mismatch %s %s: expected %0d, actual %0d", test_name, name, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("test %s finished with %0d errors", test_name, err_cnt - err_mark);
  endtask

  task automatic abort_run(input string reason);
    $display("error: %s", reason);
    $display("TESTS FAILED");
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic next_edge();
    @(posedge adc_clk);
    #(DRV_DLY);
  endtask

  task automatic wait_ack(input string what);
    int cnt;
    cnt = 0;
    while (!bus_ack && cnt < ACK_TIMEOUT) begin
      next_edge();
      cnt++;
    end
    if (!bus_ack) begin
      abort_run($sformatf("no bus acknowledge for %s within %0d cycles", what, ACK_TIMEOUT));
    end
  endtask

  // One strobe cycle, then an idle cycle after the acknowledge
  task automatic bus_write(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] data);
    bus_addr  = addr;
    bus_wdata = data;
    bus_wen   = 1'b1;
    next_edge();
    bus_wen = 1'b0;
    wait_ack("write");
    next_edge();
  endtask

  task automatic bus_read(input logic [BUS_AW-1:0] addr, output logic [BUS_DW-1:0] data);
    bus_addr = addr;
    bus_ren  = 1'b1;
    next_edge();
    bus_ren = 1'b0;
    wait_ack("read");
    data = bus_rdata;
    next_edge();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [BUS_DW-1:0]  rnd;
    logic [BUS_DW-1:0]  rdata;
    dac_t [CHN_NUM-1:0] dac_last;
    pdm_word_t          pdm_w;
    int                 ones [PDM_CHN];

    seed      = 49763;
    check_cnt = 0;
    err_cnt   = 0;
    test_cnt  = 0;
    err_mark  = 0;
    adc_clk   = 1'b0;
    top_rst   = 1'b1;
    adc_dat   = '0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;

    // Reset state, mid-scale DAC code while reset is held
    start_test("reset_state");
    repeat (4) begin
      next_edge();
      check_dac("reset dac0", DAC_RST_CODE, dac_dat[0]);
      check_dac("reset dac1", DAC_RST_CODE, dac_dat[1]);
    end
    top_rst = 1'b0;
    bus_read(ADDR_CTRL, rdata);
    check_word("reset ctrl", '0, rdata);
    bus_read(ADDR_PDM, rdata);
    check_word("reset pdm", '0, rdata);
    end_test();

    // Register readback
    start_test("reg_readback");
    bus_read(ADDR_ID, rdata);
    check_word("id", RP_ID, rdata);
    // ID is read only
    bus_write(ADDR_ID, 32'hDEAD_BEEF);
    bus_read(ADDR_ID, rdata);
    check_word("id after write", RP_ID, rdata);
    rnd = $random(seed);
    dac_last[0] = rnd[DAC_DW-1:0];
    dac_last[1] = rnd[DAC_DW+15:16];
    bus_write(ADDR_DAC0, sext_dac(dac_last[0]));
    bus_write(ADDR_DAC1, sext_dac(dac_last[1]));
    bus_read(ADDR_DAC0, rdata);
    check_word("readback dac0", sext_dac(dac_last[0]), rdata);
    bus_read(ADDR_DAC1, rdata);
    check_word("readback dac1", sext_dac(dac_last[1]), rdata);
    rnd = $random(seed);
    bus_write(ADDR_PDM, rnd);
    bus_read(ADDR_PDM, rdata);
    check_word("readback pdm", rnd, rdata);
    bus_write(ADDR_CTRL, 32'h1);
    bus_read(ADDR_CTRL, rdata);
    check_word("readback ctrl set", 32'h1, rdata);
    bus_write(ADDR_CTRL, 32'h0);
    bus_read(ADDR_CTRL, rdata);
    check_word("readback ctrl clear", 32'h0, rdata);
    bus_read(4'hA, rdata);
    check_word("unmapped read", '0, rdata);
    end_test();

    // ADC conversion, word held one edge before the read
    start_test("adc_conversion");
    for (int i = 0; i < NUM_ITER; i++) begin
      rnd = $random(seed);
      adc_dat[0] = rnd[15:0];
      adc_dat[1] = rnd[31:16];
      next_edge();
      bus_read(ADDR_ADC0, rdata);
      check_word("adc_conv ch0", sext_adc(adc_ref(rnd[15:0])), rdata);
      bus_read(ADDR_ADC1, rdata);
      check_word("adc_conv ch1", sext_adc(adc_ref(rnd[31:16])), rdata);
    end
    end_test();

    // DAC output, bus_write returns two edges after the strobe
    start_test("dac_output");
    for (int i = 0; i < NUM_ITER; i++) begin
      rnd = $random(seed);
      dac_last[0] = rnd[DAC_DW-1:0];
      dac_last[1] = rnd[DAC_DW+15:16];
      bus_write(ADDR_DAC0, sext_dac(dac_last[0]));
      check_dac("dac_out ch0", dac_ref(dac_last[0]), dac_dat[0]);
      bus_write(ADDR_DAC1, sext_dac(dac_last[1]));
      check_dac("dac_out ch1", dac_ref(dac_last[1]), dac_dat[1]);
    end
    end_test();

    // Digital loopback
    start_test("digital_loopback");
    bus_write(ADDR_CTRL, 32'h1);
    for (int i = 0; i < NUM_ITER; i++) begin
      rnd = $random(seed);
      adc_dat[0] = rnd[15:0];
      adc_dat[1] = rnd[31:16];
      next_edge();
      next_edge();
      check_dac("loop ch0", dac_ref(loop_ref(adc_ref(rnd[15:0]))), dac_dat[0]);
      check_dac("loop ch1", dac_ref(loop_ref(adc_ref(rnd[31:16]))), dac_dat[1]);
    end
    // Back to the register values
    bus_write(ADDR_CTRL, 32'h0);
    check_dac("unloop ch0", dac_ref(dac_last[0]), dac_dat[0]);
    check_dac("unloop ch1", dac_ref(dac_last[1]), dac_dat[1]);
    end_test();

    // PDM density, corner duties on channels 0 and 3
    start_test("pdm_density");
    rnd = $random(seed);
    pdm_w.raw     = rnd;
    pdm_w.duty[0] = 8'h00;
    pdm_w.duty[3] = 8'hFF;
    bus_write(ADDR_PDM, pdm_w.raw);
    repeat (PDM_SETTLE) next_edge();
    for (int c = 0; c < PDM_CHN; c++) begin
      ones[c] = 0;
    end
    for (int k = 0; k < PDM_RNG; k++) begin
      next_edge();
      for (int c = 0; c < PDM_CHN; c++) begin
        if (dac_pwm[c]) begin
          ones[c]++;
        end
      end
    end
    for (int c = 0; c < PDM_CHN; c++) begin
      check_count($sformatf("pdm ch%0d", c), pdm_ones_ref(int'(pdm_w.duty[c])), ones[c]);
    end
    end_test();

    // Assertion failures from the bound checker count as errors
    err_cnt += rp_top_i.rp_top_props_i.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/rp_top_props.sv
/*
 * Concurrent assertions on the bus acknowledge and the reset state,
 * bound into every rp_top instance.
 */

`timescale 1ns/1ps
`default_nettype none

module rp_top_props (
  input wire logic                                         adc_clk,
  input wire logic                                         top_rst,
  input wire logic                                         bus_wen_i,
  input wire logic                                         bus_ren_i,
  input wire logic                                         bus_ack_i,
  input wire logic [rp_pkg::CHN_NUM-1:0][rp_pkg::DAC_DW-1:0] dac_dat_i,
  input wire logic [rp_pkg::PDM_CHN-1:0]                   dac_pwm_i
);

  import rp_pkg::*;

  // Count of failed assertions
  int fail_cnt = 0;

  //////////////////////////////////////////////////////////////////////
  // Bus acknowledge
  //////////////////////////////////////////////////////////////////////

  ack_one_cycle: assert property (@(posedge adc_clk) disable iff (top_rst)
    bus_ack_i |=> !bus_ack_i)
    else begin
      fail_cnt++;
      $error("bus acknowledge held longer than one cycle");
    end

  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (top_rst)
    bus_ack_i |-> $past(bus_wen_i || bus_ren_i))
    else begin
      fail_cnt++;
      $error("bus acknowledge without a preceding strobe");
    end

  strobe_gets_ack: assert property (@(posedge adc_clk) disable iff (top_rst)
    (bus_wen_i || bus_ren_i) |=> bus_ack_i)
    else begin
      fail_cnt++;
      $error("bus strobe not acknowledged on the next cycle");
    end

  //////////////////////////////////////////////////////////////////////
  // Reset state
  //////////////////////////////////////////////////////////////////////

  pwm_low_in_reset: assert property (@(posedge adc_clk)
    top_rst |-> (dac_pwm_i == '0))
    else begin
      fail_cnt++;
      $error("PDM outputs not low during reset");
    end

  dac_mid_in_reset: assert property (@(posedge adc_clk)
    top_rst |-> (dac_dat_i == {CHN_NUM{DAC_RST_CODE}}))
    else begin
      fail_cnt++;
      $error("DAC outputs not at mid-scale during reset");
    end

endmodule

bind rp_top rp_top_props rp_top_props_i (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .bus_wen_i (bus_wen_i),
  .bus_ren_i (bus_ren_i),
  .bus_ack_i (bus_ack_o),
  .dac_dat_i (dac_dat_o),
  .dac_pwm_i (dac_pwm_o)
);

`default_nettype wire

// File: hw/rp_top.sv
/*
 * Top level of the analog front end. Connects ADC capture, DAC output,
 * register block and PDM modulator in the adc_clk domain.
 */

`timescale 1ns/1ps
`default_nettype none

module rp_top (
  input  wire logic                                         adc_clk,
  input  wire logic                                         top_rst,
  // ADC
  input  wire logic [rp_pkg::CHN_NUM-1:0][rp_pkg::ADC_DW-1:0] adc_dat_i,
  // DAC, one port per channel
  output logic      [rp_pkg::CHN_NUM-1:0][rp_pkg::DAC_DW-1:0] dac_dat_o,
  // PDM outputs
  output logic      [rp_pkg::PDM_CHN-1:0]                   dac_pwm_o,
  // System bus
  input  wire logic [rp_pkg::BUS_AW-1:0]                    bus_addr_i,
  input  wire logic [rp_pkg::BUS_DW-1:0]                    bus_wdata_i,
  input  wire logic                                         bus_wen_i,
  input  wire logic                                         bus_ren_i,
  output logic      [rp_pkg::BUS_DW-1:0]                    bus_rdata_o,
  output logic                                              bus_ack_o
);

  import rp_pkg::*;

  // Converted ADC samples
  adc_t [CHN_NUM-1:0] adc_smp;
  // Register outputs
  dac_t [CHN_NUM-1:0] dac_val;
  logic               digital_loop;
  pdm_word_t          pdm_cfg;

  //////////////////////////////////////////////////////////////////////
  // Front ends
  //////////////////////////////////////////////////////////////////////

  adc_frontend adc_frontend_i (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat_i),
    .adc_smp_o      (adc_smp)
  );

  dac_frontend dac_frontend_i (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .dac_val_i      (dac_val),
    .digital_loop_i (digital_loop),
    .adc_smp_i      (adc_smp),
    .dac_dat_o      (dac_dat_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Registers and PDM
  //////////////////////////////////////////////////////////////////////

  sys_regs sys_regs_i (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .bus_addr_i     (bus_addr_i),
    .bus_wdata_i    (bus_wdata_i),
    .bus_wen_i      (bus_wen_i),
    .bus_ren_i      (bus_ren_i),
    .bus_rdata_o    (bus_rdata_o),
    .bus_ack_o      (bus_ack_o),
    .adc_smp_i      (adc_smp),
    .dac_val_o      (dac_val),
    .digital_loop_o (digital_loop),
    .pdm_cfg_o      (pdm_cfg)
  );

  // Fixed range, always enabled
  pdm_modulator pdm_modulator_i (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .pdm_cfg_i      (pdm_cfg),
    .dac_pwm_o      (dac_pwm_o)
  );

endmodule

`default_nettype wire

// File: hw/sys_regs.sv
/*
 * Register block on the simple system bus. Holds control, DAC values
 * and PDM configuration, returns readback data and a one-cycle
 * acknowledge on the cycle after each read or write strobe.
 */

`timescale 1ns/1ps
`default_nettype none

module sys_regs (
  input  wire logic                                adc_clk,
  input  wire logic                                top_rst,
  // System bus
  input  wire logic [rp_pkg::BUS_AW-1:0]           bus_addr_i,
  input  wire logic [rp_pkg::BUS_DW-1:0]           bus_wdata_i,
  input  wire logic                                bus_wen_i,
  input  wire logic                                bus_ren_i,
  output logic      [rp_pkg::BUS_DW-1:0]           bus_rdata_o,
  output logic                                     bus_ack_o,
  // Live ADC samples for readback
  input  rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0]       adc_smp_i,
  // Configuration outputs
  output rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0]       dac_val_o,
  output logic                                     digital_loop_o,
  output rp_pkg::pdm_word_t                        pdm_cfg_o
);

  import rp_pkg::*;

  // Configuration registers
  logic               digital_loop_q;
  dac_t [CHN_NUM-1:0] dac_val_q;
  pdm_word_t          pdm_cfg_q;

  // Read data before the output register
  logic [BUS_DW-1:0]  rd_mux;

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////

  // Read-only and unmapped addresses fall into default
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      digital_loop_q <= 1'b0;
      dac_val_q      <= '0;
      pdm_cfg_q      <= '0;
    end else if (bus_wen_i) begin
      case (bus_addr_i)
        ADDR_CTRL: digital_loop_q <= bus_wdata_i[0];
        ADDR_DAC0: dac_val_q[0]   <= bus_wdata_i[DAC_DW-1:0];
        ADDR_DAC1: dac_val_q[1]   <= bus_wdata_i[DAC_DW-1:0];
        ADDR_PDM:  pdm_cfg_q.raw  <= bus_wdata_i;
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (bus_addr_i)
      ADDR_ID:   rd_mux = RP_ID;
      ADDR_CTRL: rd_mux = {{(BUS_DW-1){1'b0}}, digital_loop_q};
      // Signed values are sign extended to the bus width
      ADDR_DAC0: rd_mux = {{(BUS_DW-DAC_DW){dac_val_q[0][DAC_DW-1]}}, dac_val_q[0]};
      ADDR_DAC1: rd_mux = {{(BUS_DW-DAC_DW){dac_val_q[1][DAC_DW-1]}}, dac_val_q[1]};
      ADDR_PDM:  rd_mux = pdm_cfg_q.raw;
      ADDR_ADC0: rd_mux = {{(BUS_DW-ADC_DW){adc_smp_i[0][ADC_DW-1]}}, adc_smp_i[0]};
      ADDR_ADC1: rd_mux = {{(BUS_DW-ADC_DW){adc_smp_i[1][ADC_DW-1]}}, adc_smp_i[1]};
      default:   rd_mux = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Acknowledge and read data
  //////////////////////////////////////////////////////////////////////

  // Data only during a read acknowledge, zero otherwise
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      bus_ack_o   <= 1'b0;
      bus_rdata_o <= '0;
    end else begin
      bus_ack_o <= bus_wen_i | bus_ren_i;
      if (bus_ren_i) begin
        bus_rdata_o <= rd_mux;
      end else begin
        bus_rdata_o <= '0;
      end
    end
  end

  // Register outputs to the front ends and modulator
  assign digital_loop_o = digital_loop_q;
  assign dac_val_o      = dac_val_q;
  assign pdm_cfg_o      = pdm_cfg_q;

endmodule

`default_nettype wire

// File: hw/pdm_modulator.sv
/*
 * Four first-order pulse-density modulators. Each one spreads its duty
 * byte as evenly spaced ones over a period of PDM_RNG clock cycles.
 */

`timescale 1ns/1ps
`default_nettype none

module pdm_modulator (
  input  wire logic                       adc_clk,
  input  wire logic                       top_rst,
  // Duty bytes packed in one word
  input  rp_pkg::pdm_word_t               pdm_cfg_i,
  // One-bit outputs to the RC filters
  output logic [rp_pkg::PDM_CHN-1:0]      dac_pwm_o
);

  import rp_pkg::*;

  // Accumulators, one extra bit for the carry past the range
  logic [PDM_CHN-1:0][PDM_DW-1:0] acc;
  logic [PDM_CHN-1:0][PDM_DW:0]   acc_sum;
  logic [PDM_CHN-1:0]             acc_ovf;

  //////////////////////////////////////////////////////////////////////
  // Accumulate and compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < PDM_CHN; i++) begin
      acc_sum[i] = {1'b0, acc[i]} + {1'b0, pdm_cfg_i.duty[i]};
      // Range reached, emit a one this cycle
      acc_ovf[i] = (acc_sum[i] >= (PDM_DW+1)'(PDM_RNG));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State and output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      acc       <= '0;
      dac_pwm_o <= '0;
    end else begin
      for (int i = 0; i < PDM_CHN; i++) begin
        // Wrap back into 0..PDM_RNG-1
        if (acc_ovf[i]) begin
          acc[i] <= PDM_DW'(acc_sum[i] - (PDM_DW+1)'(PDM_RNG));
        end else begin
          acc[i] <= acc_sum[i][PDM_DW-1:0];
        end
      end
      dac_pwm_o <= acc_ovf;
    end
  end

endmodule

`default_nettype wire

// File: hw/dac_frontend.sv
/*
 * DAC output stage. Picks the register value or the looped-back ADC
 * sample per channel, converts it to the negative-slope raw code and
 * holds it in the output registers.
 */

`timescale 1ns/1ps
`default_nettype none

module dac_frontend (
  input  wire logic                                   adc_clk,
  input  wire logic                                   top_rst,
  // Values written over the bus
  input  rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0]          dac_val_i,
  // Route ADC samples to the DAC
  input  wire logic                                   digital_loop_i,
  input  rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0]          adc_smp_i,
  // Raw codes to the converter pins
  output logic [rp_pkg::CHN_NUM-1:0][rp_pkg::DAC_DW-1:0] dac_dat_o
);

  import rp_pkg::*;

  // Selected signed source per channel
  dac_t [CHN_NUM-1:0] dac_src;
  // Next raw code
  logic [CHN_NUM-1:0][DAC_DW-1:0] dac_nxt;

  //////////////////////////////////////////////////////////////////////
  // Source select and conversion
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < CHN_NUM; i++) begin
      // Loopback keeps the top DAC_DW bits of the sample
      if (digital_loop_i) begin
        dac_src[i] = adc_smp_i[i][ADC_DW-1 -: DAC_DW];
      end else begin
        dac_src[i] = dac_val_i[i];
      end
      // Back to negative slope, sign bit untouched
      dac_nxt[i] = {dac_src[i][DAC_DW-1], ~dac_src[i][DAC_DW-2:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  // Mid-scale code on both channels while in reset
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= {CHN_NUM{DAC_RST_CODE}};
    end else begin
      dac_dat_o <= dac_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hw/adc_frontend.sv
/*
 * ADC capture stage. Registers both raw converter words and turns the
 * negative-slope offset binary code into two's complement samples.
 */

`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  wire logic                                        adc_clk,
  input  wire logic                                        top_rst,
  // Raw converter words
  input  wire logic [rp_pkg::CHN_NUM-1:0][rp_pkg::ADC_DW-1:0] adc_dat_i,
  // Converted samples
  output rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0]               adc_smp_o
);

  import rp_pkg::*;

  // Input capture registers, one per channel
  logic [CHN_NUM-1:0][ADC_DW-1:0] adc_raw;

  //////////////////////////////////////////////////////////////////////
  // Capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= adc_dat_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Conversion
  //////////////////////////////////////////////////////////////////////

  // Sign kept, magnitude bits inverted for the negative slope
  always_comb begin
    for (int i = 0; i < CHN_NUM; i++) begin
      adc_smp_o[i] = {adc_raw[i][ADC_DW-1], ~adc_raw[i][ADC_DW-2:0]};
    end
  end

endmodule

`default_nettype wire

// File: hw/rp_pkg.sv
/*
 * Shared widths, register map, ID constant and data types for the
 * two-channel analog front end. Modules import it inside their body.
 */

`default_nettype none

package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_DW  = 16;
  localparam int unsigned DAC_DW  = 14;
  localparam int unsigned CHN_NUM = 2;
  localparam int unsigned PDM_CHN = 4;
  localparam int unsigned PDM_DW  = 8;
  // Full PDM period in clock cycles
  localparam int unsigned PDM_RNG = 255;
  localparam int unsigned BUS_AW  = 4;
  localparam int unsigned BUS_DW  = 32;

  // Raw mid-scale code held by the DAC while in reset
  localparam logic [DAC_DW-1:0] DAC_RST_CODE = 14'h1FFF;

  // Board identification word
  localparam logic [BUS_DW-1:0] RP_ID = 32'h5250_0A01;

  //////////////////////////////////////////////////////////////////////
  // Register map, word addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [BUS_AW-1:0] ADDR_ID   = 4'd0;
  localparam logic [BUS_AW-1:0] ADDR_CTRL = 4'd1;  // bit 0 digital_loop
  localparam logic [BUS_AW-1:0] ADDR_DAC0 = 4'd2;
  localparam logic [BUS_AW-1:0] ADDR_DAC1 = 4'd3;
  localparam logic [BUS_AW-1:0] ADDR_PDM  = 4'd4;
  localparam logic [BUS_AW-1:0] ADDR_ADC0 = 4'd5;
  localparam logic [BUS_AW-1:0] ADDR_ADC1 = 4'd6;

  // Two's complement sample types
  typedef logic signed [ADC_DW-1:0] adc_t;
  typedef logic signed [DAC_DW-1:0] dac_t;

  // PDM config, one bus word or four duty bytes (byte n to channel n)
  typedef union packed {
    logic [BUS_DW-1:0]              raw;
    logic [PDM_CHN-1:0][PDM_DW-1:0] duty;
  } pdm_word_t;

endpackage

`default_nettype wire
